/* source/rv_pkg.sv */
`default_nettype none

package rv_pkg;

    typedef logic [31:0] word_t;      // data or address word
    typedef logic [4:0]  reg_addr_t;
    typedef logic [3:0]  alu_op_t;

    localparam alu_op_t ALU_ADD   = 4'd0;
    localparam alu_op_t ALU_SUB   = 4'd1;
    localparam alu_op_t ALU_SLL   = 4'd2;
    localparam alu_op_t ALU_SLT   = 4'd3;
    localparam alu_op_t ALU_SLTU  = 4'd4;
    localparam alu_op_t ALU_XOR   = 4'd5;
    localparam alu_op_t ALU_SRL   = 4'd6;
    localparam alu_op_t ALU_SRA   = 4'd7;
    localparam alu_op_t ALU_OR    = 4'd8;
    localparam alu_op_t ALU_AND   = 4'd9;
    localparam alu_op_t ALU_PASSB = 4'd10;   // operand b straight through

    // major opcodes, inst[6:0]
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_SYSTEM = 7'b1110011;

    localparam word_t       RESET_PC   = 32'h0000_0000;
    localparam logic [11:0] CSR_TOHOST = 12'h51e;
    localparam word_t       NOP_INST   = 32'h0000_0013;   // addi x0,x0,0

    typedef struct packed {
        word_t pc;
        word_t inst;
        logic  valid;
    } if_pkt_s;

    typedef struct packed {
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        word_t     imm;
        alu_op_t   alu_op;
        logic      use_imm;     // operand b from imm
        logic      is_lui;      // operand a forced to zero
        logic      is_branch;
        logic      branch_ne;
        logic      is_jal;
        logic      reg_we;
        logic      csr_we;      // csrrw to tohost
    } dec_ctrl_s;

    typedef struct packed {
        logic      we;
        reg_addr_t rd;
        word_t     data;
    } wb_s;

    typedef enum logic [1:0] {
        F_IDLE,
        F_REQ,
        F_WAIT_LOW
    } fetch_state_e;

endpackage

`default_nettype wire

/* source/regfile.sv */
`default_nettype none

module regfile (
    input  logic              clk,
    input  rv_pkg::reg_addr_t ra1_i,
    input  rv_pkg::reg_addr_t ra2_i,
    output rv_pkg::word_t     rd1_o,
    output rv_pkg::word_t     rd2_o,
    input  rv_pkg::wb_s       wb_i
);

    rv_pkg::word_t regs [32];

    always_ff @(posedge clk) begin
        if (wb_i.we && wb_i.rd != '0) begin
            regs[wb_i.rd] <= wb_i.data;
        end
    end

    // x0 entry is never written, so mask it on read
    assign rd1_o = (ra1_i == '0) ? '0 : regs[ra1_i];
    assign rd2_o = (ra2_i == '0) ? '0 : regs[ra2_i];

endmodule

`default_nettype wire

/* source/decoder.sv */
`default_nettype none

module decoder (
    input  rv_pkg::if_pkt_s   pkt_i,
    output rv_pkg::dec_ctrl_s ctrl_o
);

    rv_pkg::word_t inst;
    logic [6:0]    opcode;
    logic [2:0]    funct3;
    logic [6:0]    funct7;
    rv_pkg::word_t imm_i;
    rv_pkg::word_t imm_u;
    rv_pkg::word_t imm_b;
    rv_pkg::word_t imm_j;

    // empty slot decodes as a plain nop
    assign inst   = pkt_i.valid ? pkt_i.inst : rv_pkg::NOP_INST;
    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        ctrl_o        = '0;              // anything unknown writes nothing
        ctrl_o.rs1    = inst[19:15];
        ctrl_o.rs2    = inst[24:20];
        ctrl_o.rd     = inst[11:7];
        ctrl_o.alu_op = rv_pkg::ALU_ADD;
        case (opcode)
            rv_pkg::OP_IMM: begin
                ctrl_o.imm     = imm_i;
                ctrl_o.use_imm = 1'b1;
                ctrl_o.reg_we  = 1'b1;
                case (funct3)
                    3'b000: ctrl_o.alu_op = rv_pkg::ALU_ADD;
                    3'b001: begin
                        ctrl_o.alu_op = rv_pkg::ALU_SLL;
                        ctrl_o.reg_we = (funct7 == 7'h00);
                    end
                    3'b010: ctrl_o.alu_op = rv_pkg::ALU_SLT;
                    3'b011: ctrl_o.alu_op = rv_pkg::ALU_SLTU;
                    3'b100: ctrl_o.alu_op = rv_pkg::ALU_XOR;
                    3'b101: begin
                        ctrl_o.alu_op = inst[30] ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
                        ctrl_o.reg_we = (funct7 == 7'h00) || (funct7 == 7'h20);
                    end
                    3'b110: ctrl_o.alu_op = rv_pkg::ALU_OR;
                    default: ctrl_o.alu_op = rv_pkg::ALU_AND;
                endcase
            end
            rv_pkg::OP_REG: begin
                // only sub and sra carry funct7 bit 5
                ctrl_o.reg_we = (funct7 == 7'h00) ||
                                (funct7 == 7'h20 && (funct3 == 3'b000 || funct3 == 3'b101));
                case (funct3)
                    3'b000: ctrl_o.alu_op = funct7[5] ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
                    3'b001: ctrl_o.alu_op = rv_pkg::ALU_SLL;
                    3'b010: ctrl_o.alu_op = rv_pkg::ALU_SLT;
                    3'b011: ctrl_o.alu_op = rv_pkg::ALU_SLTU;
                    3'b100: ctrl_o.alu_op = rv_pkg::ALU_XOR;
                    3'b101: ctrl_o.alu_op = funct7[5] ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
                    3'b110: ctrl_o.alu_op = rv_pkg::ALU_OR;
                    default: ctrl_o.alu_op = rv_pkg::ALU_AND;
                endcase
            end
            rv_pkg::OP_LUI: begin
                ctrl_o.imm     = imm_u;
                ctrl_o.use_imm = 1'b1;
                ctrl_o.is_lui  = 1'b1;   // 0 + imm
                ctrl_o.reg_we  = 1'b1;
            end
            rv_pkg::OP_JAL: begin
                ctrl_o.imm    = imm_j;
                ctrl_o.is_jal = 1'b1;
                ctrl_o.reg_we = 1'b1;
            end
            rv_pkg::OP_BRANCH: begin
                if (funct3[2:1] == 2'b00) begin      // beq, bne
                    ctrl_o.imm       = imm_b;
                    ctrl_o.alu_op    = rv_pkg::ALU_SUB;
                    ctrl_o.is_branch = 1'b1;
                    ctrl_o.branch_ne = funct3[0];
                end
            end
            rv_pkg::OP_SYSTEM: begin
                if (funct3 == 3'b001 && inst[31:20] == rv_pkg::CSR_TOHOST) begin
                    // rs1 value rides operand b so the b forward path covers it
                    ctrl_o.rs2    = inst[19:15];
                    ctrl_o.alu_op = rv_pkg::ALU_PASSB;
                    ctrl_o.csr_we = 1'b1;
                end
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* source/exec_unit.sv */
`default_nettype none

module exec_unit (
    input  rv_pkg::word_t     pc_i,
    input  rv_pkg::dec_ctrl_s ctrl_i,
    input  rv_pkg::word_t     rd1_i,
    input  rv_pkg::word_t     rd2_i,
    input  rv_pkg::wb_s       wb_i,
    input  logic              fwd_a_i,
    input  logic              fwd_b_i,
    output rv_pkg::word_t     alu_res_o,
    output rv_pkg::word_t     link_o,
    output logic              taken_o,
    output rv_pkg::word_t     target_o
);

    rv_pkg::word_t rs1_val;
    rv_pkg::word_t rs2_val;
    rv_pkg::word_t op_a;
    rv_pkg::word_t op_b;
    logic [4:0]    shamt;

    assign rs1_val = fwd_a_i ? wb_i.data : rd1_i;
    assign rs2_val = fwd_b_i ? wb_i.data : rd2_i;
    assign op_a    = ctrl_i.is_lui ? '0 : rs1_val;
    assign op_b    = ctrl_i.use_imm ? ctrl_i.imm : rs2_val;
    assign shamt   = op_b[4:0];

    always_comb begin
        case (ctrl_i.alu_op)
            rv_pkg::ALU_SUB:   alu_res_o = op_a - op_b;
            rv_pkg::ALU_SLL:   alu_res_o = op_a << shamt;
            rv_pkg::ALU_SLT:   alu_res_o = {31'b0, $signed(op_a) < $signed(op_b)};
            rv_pkg::ALU_SLTU:  alu_res_o = {31'b0, op_a < op_b};
            rv_pkg::ALU_XOR:   alu_res_o = op_a ^ op_b;
            rv_pkg::ALU_SRL:   alu_res_o = op_a >> shamt;
            rv_pkg::ALU_SRA:   alu_res_o = $signed(op_a) >>> shamt;
            rv_pkg::ALU_OR:    alu_res_o = op_a | op_b;
            rv_pkg::ALU_AND:   alu_res_o = op_a & op_b;
            rv_pkg::ALU_PASSB: alu_res_o = op_b;
            default:           alu_res_o = op_a + op_b;   // add
        endcase
    end

    // beq when equal, bne when not
    assign taken_o  = ctrl_i.is_jal |
                      (ctrl_i.is_branch & ((rs1_val == rs2_val) ^ ctrl_i.branch_ne));
    assign target_o = pc_i + ctrl_i.imm;
    assign link_o   = pc_i + 32'd4;

endmodule

`default_nettype wire

/* source/fetch_unit.sv */
`default_nettype none

module fetch_unit (
    input  logic            clk,
    input  logic            rst_n_i,
    input  logic            redirect_i,
    input  rv_pkg::word_t   redirect_pc_i,
    input  logic            consume_i,
    output logic            imem_req_o,
    output rv_pkg::word_t   imem_addr_o,
    input  logic            imem_ack_i,
    input  rv_pkg::word_t   imem_data_i,
    output rv_pkg::if_pkt_s pkt_o
);

    rv_pkg::fetch_state_e state_q;
    rv_pkg::word_t        pc_q;        // next address to request
    rv_pkg::word_t        addr_q;      // address of the live request
    rv_pkg::word_t        fetch_pc;
    rv_pkg::word_t        pkt_pc_q;
    rv_pkg::word_t        pkt_inst_q;
    logic                 pkt_valid_q;
    logic                 discard_q;   // outstanding word is wrong-path
    logic                 launch;
    logic                 take;
    logic                 drop;

    assign fetch_pc = redirect_i ? redirect_pc_i : pc_q;
    assign launch   = (state_q != rv_pkg::F_REQ) && !imem_ack_i;
    assign take     = (state_q == rv_pkg::F_REQ) && imem_ack_i && (!pkt_valid_q || consume_i);
    assign drop     = take && (discard_q || redirect_i);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q     <= rv_pkg::F_IDLE;
            pc_q        <= rv_pkg::RESET_PC;
            pkt_valid_q <= 1'b0;
            discard_q   <= 1'b0;
        end else begin
            pc_q <= launch ? fetch_pc + 32'd4 : fetch_pc;
            if (launch) begin
                state_q <= rv_pkg::F_REQ;
            end else if (take) begin
                state_q <= rv_pkg::F_WAIT_LOW;    // drop req and wait for ack low
            end
            if (take) begin
                discard_q <= 1'b0;
            end else if (redirect_i && state_q == rv_pkg::F_REQ) begin
                discard_q <= 1'b1;
            end
            if (take && !drop) begin
                pkt_valid_q <= 1'b1;
            end else if (consume_i || redirect_i) begin
                pkt_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (launch) begin
            addr_q <= fetch_pc;
        end
        if (take) begin
            pkt_pc_q   <= addr_q;
            pkt_inst_q <= imem_data_i;
        end
    end

    assign imem_req_o  = (state_q == rv_pkg::F_REQ);
    assign imem_addr_o = addr_q;
    assign pkt_o.pc    = pkt_pc_q;
    assign pkt_o.inst  = pkt_inst_q;
    assign pkt_o.valid = pkt_valid_q;

    a_req_rise: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        $rose(imem_req_o) |-> !imem_ack_i
    ) else $error("req raised while ack still high");

endmodule

`default_nettype wire

/* source/pipe_ctrl.sv */
`default_nettype none

module pipe_ctrl (
    input  logic              clk,
    input  logic              rst_n_i,
    input  rv_pkg::if_pkt_s   pkt_i,
    input  rv_pkg::dec_ctrl_s ctrl_i,
    input  rv_pkg::word_t     alu_res_i,
    input  rv_pkg::word_t     link_i,
    input  logic              taken_i,
    input  rv_pkg::word_t     target_i,
    output logic              stall_o,
    output logic              redirect_o,
    output rv_pkg::word_t     redirect_pc_o,
    output logic              fwd_a_o,
    output logic              fwd_b_o,
    output rv_pkg::wb_s       wb_o,
    output rv_pkg::word_t     csr_o
);

    logic              ex_valid;
    logic              wb_we_q;
    rv_pkg::reg_addr_t wb_rd_q;
    rv_pkg::word_t     wb_data_q;
    rv_pkg::word_t     tohost_q;

    assign ex_valid = pkt_i.valid;
    assign stall_o  = ~ex_valid;     // empty slot becomes a bubble

    // wrong-path fetch is dropped inside fetch_unit
    assign redirect_o    = ex_valid & taken_i;
    assign redirect_pc_o = target_i;

    // writeback result bypasses the regfile write of the next edge
    assign fwd_a_o = wb_we_q && (wb_rd_q != '0) && (wb_rd_q == ctrl_i.rs1);
    assign fwd_b_o = wb_we_q && (wb_rd_q != '0) && (wb_rd_q == ctrl_i.rs2);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wb_we_q  <= 1'b0;
            tohost_q <= '0;
        end else begin
            wb_we_q <= ex_valid & ctrl_i.reg_we;
            if (ex_valid && ctrl_i.csr_we) begin
                tohost_q <= alu_res_i;
            end
        end
    end

    // payload follows the execute slot every cycle
    always_ff @(posedge clk) begin
        wb_rd_q   <= ctrl_i.rd;
        wb_data_q <= ctrl_i.is_jal ? link_i : alu_res_i;   // jal writes pc+4
    end

    assign wb_o.we   = wb_we_q;
    assign wb_o.rd   = wb_rd_q;
    assign wb_o.data = wb_data_q;
    assign csr_o     = tohost_q;

    // decoder turns an empty packet into a nop, so no branch can fire from it
    a_no_redirect_on_bubble: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        taken_i |-> pkt_i.valid
    ) else $error("taken branch from an empty execute slot");

endmodule

`default_nettype wire

/* source/rv_core_top.sv */
`default_nettype none

module rv_core_top (
    input  logic          clk,
    input  logic          rst_n_i,
    output logic          imem_req_o,
    output rv_pkg::word_t imem_addr_o,
    input  logic          imem_ack_i,
    input  rv_pkg::word_t imem_data_i,
    output rv_pkg::word_t csr_o
);

    rv_pkg::if_pkt_s   if_pkt;
    rv_pkg::dec_ctrl_s ex_ctrl;
    rv_pkg::wb_s       wb;

    rv_pkg::word_t rf_rd1;
    rv_pkg::word_t rf_rd2;
    rv_pkg::word_t alu_res;
    rv_pkg::word_t link_addr;
    rv_pkg::word_t br_target;
    rv_pkg::word_t redirect_pc;
    logic          br_taken;
    logic          redirect;
    logic          ex_stall;
    logic          fwd_a;
    logic          fwd_b;

    fetch_unit fetch (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .redirect_i    (redirect),
        .redirect_pc_i (redirect_pc),
        .consume_i     (~ex_stall),     // a valid packet never waits
        .imem_req_o    (imem_req_o),
        .imem_addr_o   (imem_addr_o),
        .imem_ack_i    (imem_ack_i),
        .imem_data_i   (imem_data_i),
        .pkt_o         (if_pkt)
    );

    decoder dec (
        .pkt_i  (if_pkt),
        .ctrl_o (ex_ctrl)
    );

    regfile rf (
        .clk    (clk),
        .ra1_i  (ex_ctrl.rs1),
        .ra2_i  (ex_ctrl.rs2),
        .rd1_o  (rf_rd1),
        .rd2_o  (rf_rd2),
        .wb_i   (wb)
    );

    exec_unit ex (
        .pc_i      (if_pkt.pc),
        .ctrl_i    (ex_ctrl),
        .rd1_i     (rf_rd1),
        .rd2_i     (rf_rd2),
        .wb_i      (wb),
        .fwd_a_i   (fwd_a),
        .fwd_b_i   (fwd_b),
        .alu_res_o (alu_res),
        .link_o    (link_addr),
        .taken_o   (br_taken),
        .target_o  (br_target)
    );

    pipe_ctrl ctrl (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .pkt_i         (if_pkt),
        .ctrl_i        (ex_ctrl),
        .alu_res_i     (alu_res),
        .link_i        (link_addr),
        .taken_i       (br_taken),
        .target_i      (br_target),
        .stall_o       (ex_stall),
        .redirect_o    (redirect),
        .redirect_pc_o (redirect_pc),
        .fwd_a_o       (fwd_a),
        .fwd_b_o       (fwd_b),
        .wb_o          (wb),
        .csr_o         (csr_o)
    );

endmodule

`default_nettype wire

/* test/tb_imem_model.sv */
`default_nettype none

module tb_imem_model (
    input  logic          clk,
    input  logic          rst_n_i,
    input  logic          random_delay_i,   // 0 gives fixed zero delay
    input  logic          req_i,
    input  rv_pkg::word_t addr_i,
    output logic          ack_o,
    output rv_pkg::word_t data_o
);

    timeunit 1ns;
    timeprecision 100ps;

    rv_pkg::word_t mem [256];   // loaded by the testbench
    logic          ack_q = 1'b0;
    rv_pkg::word_t data_q = '0;
    logic          busy;
    int            cnt;
    int            proto_errs = 0;

    assign ack_o  = ack_q;
    assign data_o = data_q;

    always @(posedge clk) begin
        if (!rst_n_i) begin
            ack_q  <= 1'b0;
            busy   <= 1'b0;
            cnt    <= 0;
            data_q <= '0;
        end else if (ack_q) begin
            if (!req_i) begin
                ack_q <= 1'b0;   // phase four
            end
        end else if (req_i) begin
            if (!busy) begin
                busy <= 1'b1;
                cnt  <= random_delay_i ? int'($urandom % 6) : 0;
            end else if (cnt == 0) begin
                ack_q  <= 1'b1;
                data_q <= mem[addr_i[9:2]];
                busy   <= 1'b0;
            end else begin
                cnt <= cnt - 1;
            end
        end
    end

    a_req_held: assert property (@(posedge clk) disable iff (!rst_n_i)
        $fell(req_i) |-> $past(ack_o)
    ) else begin
        proto_errs++;
        $display("req dropped before ack was seen");
    end

    a_addr_held: assert property (@(posedge clk) disable iff (!rst_n_i)
        req_i && $past(req_i) |-> $stable(addr_i)
    ) else begin
        proto_errs++;
        $display("fetch address changed while req was high");
    end

    a_no_early_req: assert property (@(posedge clk) disable iff (!rst_n_i)
        $rose(req_i) |-> !$past(ack_o)
    ) else begin
        proto_errs++;
        $display("req raised again while ack was still high");
    end

endmodule

`default_nettype wire

/* test/tb_rv_core.sv */
`default_nettype none

module tb_rv_core;

    timeunit 1ns;
    timeprecision 100ps;

    logic          clk = 1'b0;
    logic          rst_n = 1'b0;
    logic          random_delay = 1'b0;
    logic          imem_req;
    logic          imem_ack;
    rv_pkg::word_t imem_addr;
    rv_pkg::word_t imem_data;
    rv_pkg::word_t csr;

    rv_pkg::word_t prog [$];
    rv_pkg::word_t exp_mem [16];
    int            exp_len = 0;
    int            exp_idx = 0;
    rv_pkg::word_t exp_val;
    rv_pkg::word_t csr_prev;
    logic          csr_changed;
    logic          first_req_pending;
    int            rst_cnt = 0;
    int            tohost_errs = 0;
    int            other_errs = 0;
    string         test_name = "none";

    always #4 clk = ~clk;

    tb_imem_model imem (
        .clk            (clk),
        .rst_n_i        (rst_n),
        .random_delay_i (random_delay),
        .req_i          (imem_req),
        .addr_i         (imem_addr),
        .ack_o          (imem_ack),
        .data_o         (imem_data)
    );

    rv_core_top UUT (
        .clk         (clk),
        .rst_n_i     (rst_n),
        .imem_req_o  (imem_req),
        .imem_addr_o (imem_addr),
        .imem_ack_i  (imem_ack),
        .imem_data_i (imem_data),
        .csr_o       (csr)
    );

    // next value tohost has to take
    assign exp_val     = (exp_idx < exp_len) ? exp_mem[exp_idx[3:0]] : 32'hffff_0bad;
    assign csr_changed = (csr != csr_prev);

    always @(posedge clk) begin
        if (!rst_n) begin
            csr_prev          <= '0;
            exp_idx           <= 0;
            first_req_pending <= 1'b1;
            rst_cnt           <= rst_cnt + 1;
        end else begin
            csr_prev <= csr;
            rst_cnt  <= 0;
            if (csr_changed) exp_idx <= exp_idx + 1;
            if (imem_req) first_req_pending <= 1'b0;
        end
    end

    a_tohost: assert property (@(posedge clk) disable iff (!rst_n)
        csr_changed |-> csr == exp_val
    ) else begin
        tohost_errs++;
        $display("mismatch %s expected %h actual %h", test_name, exp_val, csr);
    end

    // registers settle on the first reset edge
    a_reset_quiet: assert property (@(posedge clk)
        !rst_n && rst_cnt > 1 |-> !imem_req && csr == '0
    ) else begin
        other_errs++;
        $display("req or tohost active during reset in %s", test_name);
    end

    a_first_addr: assert property (@(posedge clk) disable iff (!rst_n)
        imem_req && first_req_pending |-> imem_addr == rv_pkg::RESET_PC
    ) else begin
        other_errs++;
        $display("first fetch after reset in %s did not address zero", test_name);
    end

    function automatic rv_pkg::word_t i_type(logic [31:0] imm, logic [4:0] rs1,
                                             logic [2:0] f3, logic [4:0] rd);
        return {imm[11:0], rs1, f3, rd, rv_pkg::OP_IMM};
    endfunction

    function automatic rv_pkg::word_t r_type(logic [6:0] f7, logic [4:0] rs2,
                                             logic [4:0] rs1, logic [2:0] f3, logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, rv_pkg::OP_REG};
    endfunction

    function automatic rv_pkg::word_t b_type(logic [31:0] off, logic [4:0] rs2,
                                             logic [4:0] rs1, logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rv_pkg::OP_BRANCH};
    endfunction

    function automatic rv_pkg::word_t j_type(logic [31:0] off, logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, rv_pkg::OP_JAL};
    endfunction

    function automatic rv_pkg::word_t lui(logic [19:0] imm, logic [4:0] rd);
        return {imm, rd, rv_pkg::OP_LUI};
    endfunction

    function automatic rv_pkg::word_t to_host(logic [4:0] rs1);
        return {rv_pkg::CSR_TOHOST, rs1, 3'b001, 5'd0, rv_pkg::OP_SYSTEM};
    endfunction

    task automatic emit(rv_pkg::word_t w, int gap);
        prog.push_back(w);
        for (int i = 0; i < gap; i++) prog.push_back(rv_pkg::NOP_INST);
    endtask

    task automatic expect_seq(rv_pkg::word_t v [$]);
        exp_len = v.size();
        foreach (v[i]) exp_mem[i] = v[i];
    endtask

    task automatic build_alu();
        prog.delete();
        emit(i_type(5, 0, 3'b000, 1), 0);
        emit(to_host(1), 0);
        emit(i_type(-3, 0, 3'b000, 2), 0);
        emit(to_host(2), 0);
        emit(r_type(7'h00, 2, 1, 3'b000, 3), 0);    // add
        emit(to_host(3), 0);
        emit(r_type(7'h20, 2, 1, 3'b000, 4), 0);    // sub
        emit(to_host(4), 0);
        emit(r_type(7'h00, 2, 1, 3'b111, 5), 0);    // and
        emit(to_host(5), 0);
        emit(r_type(7'h00, 2, 1, 3'b110, 6), 0);    // or
        emit(to_host(6), 0);
        emit(r_type(7'h00, 2, 1, 3'b100, 7), 0);    // xor
        emit(to_host(7), 0);
        emit(r_type(7'h00, 1, 2, 3'b010, 8), 0);    // slt
        emit(to_host(8), 0);
        emit(r_type(7'h00, 1, 2, 3'b011, 9), 0);    // sltu
        emit(to_host(9), 0);
        emit(r_type(7'h00, 1, 1, 3'b001, 10), 0);   // sll
        emit(to_host(10), 0);
        emit(r_type(7'h00, 1, 2, 3'b101, 11), 0);   // srl
        emit(to_host(11), 0);
        emit(r_type(7'h20, 1, 2, 3'b101, 12), 0);   // sra
        emit(to_host(12), 0);
        emit(lui(20'h12345, 13), 0);
        emit(to_host(13), 0);
        emit(j_type(0, 0), 0);                 // park here
        expect_seq('{32'd5, 32'hffff_fffd, 32'd2, 32'd8, 32'd5, 32'hffff_fffd,
                     32'hffff_fff8, 32'd1, 32'd0, 32'h0000_00a0, 32'h07ff_ffff,
                     32'hffff_ffff, 32'h1234_5000});
    endtask

    task automatic build_chain(int gap);
        prog.delete();
        emit(i_type(1, 0, 3'b000, 1), gap);
        emit(r_type(7'h00, 1, 1, 3'b000, 2), gap);
        emit(r_type(7'h00, 1, 2, 3'b000, 3), gap);
        emit(to_host(3), gap);
        emit(r_type(7'h20, 2, 3, 3'b000, 4), gap);
        emit(to_host(4), gap);
        emit(r_type(7'h00, 3, 4, 3'b000, 5), gap);
        emit(to_host(5), gap);
        emit(r_type(7'h00, 4, 5, 3'b001, 6), gap);
        emit(to_host(6), gap);
        emit(j_type(0, 0), 0);
        expect_seq('{32'd3, 32'd1, 32'd4, 32'd8});
    endtask

    // skipped slots write the marker in x9
    task automatic build_branch();
        prog.delete();
        emit(i_type(32'h0bad, 0, 3'b000, 9), 0);  // 0
        emit(i_type(7, 0, 3'b000, 1), 0);         // 4
        emit(i_type(7, 0, 3'b000, 2), 0);         // 8
        emit(b_type(12, 2, 1, 3'b000), 0);        // 12 beq taken to 24
        emit(to_host(9), 0);
        emit(to_host(9), 0);
        emit(i_type(32'h11, 0, 3'b000, 3), 0);    // 24
        emit(to_host(3), 0);
        emit(b_type(8, 2, 1, 3'b001), 0);         // 32 bne not taken
        emit(i_type(32'h22, 0, 3'b000, 4), 0);    // 36
        emit(to_host(4), 0);
        emit(b_type(12, 3, 1, 3'b001), 0);        // 44 bne taken to 56
        emit(to_host(9), 0);
        emit(to_host(9), 0);
        emit(b_type(8, 3, 1, 3'b000), 0);         // 56 beq not taken
        emit(i_type(32'h33, 0, 3'b000, 5), 0);    // 60
        emit(to_host(5), 0);
        emit(j_type(12, 6), 0);                   // 68 jal to 80 with link x6 = 72
        emit(to_host(9), 0);
        emit(to_host(9), 0);
        emit(to_host(6), 0);                      // 80
        emit(j_type(0, 0), 0);
        expect_seq('{32'h11, 32'h22, 32'h33, 32'd72});
    endtask

    task automatic run_test(string name, logic rand_ack);
        int            cycles;
        logic [31:0]   idx;
        @(posedge clk);
        rst_n        <= 1'b0;
        random_delay <= rand_ack;
        test_name     = name;
        for (int i = 0; i < 256; i++) begin
            idx = i;
            // unused words are nops whose immediate carries the address
            imem.mem[i] = (i < prog.size()) ? prog[i] : {idx[11:0], 20'h00013};
        end
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        cycles = 0;
        while (exp_idx < exp_len && cycles < 3000) begin
            @(posedge clk);
            cycles++;
        end
        cycles = 0;
        while (cycles < 40) begin   // give a stray marker time to appear
            @(posedge clk);
            cycles++;
        end
        if (exp_idx != exp_len) begin
            other_errs++;
            $display("timeout in %s, %0d of %0d tohost values seen", name, exp_idx, exp_len);
        end
    endtask

    initial begin
        void'($urandom(44));
        build_alu();
        run_test("alu", 1'b0);
        build_chain(0);
        run_test("fwd_back_to_back", 1'b0);
        build_chain(3);
        run_test("fwd_with_nops", 1'b0);
        build_branch();
        run_test("branch_jal", 1'b0);
        build_alu();
        run_test("alu_random_ack", 1'b1);
        build_branch();
        run_test("branch_random_ack", 1'b1);
        build_chain(0);
        run_test("fwd_random_ack", 1'b1);

        $display("errors: %0d tohost mismatches, %0d other, %0d handshake",
                 tohost_errs, other_errs, imem.proto_errs);
        if (tohost_errs + other_errs + imem.proto_errs == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
source/rv_pkg.sv
source/regfile.sv
source/decoder.sv
source/exec_unit.sv
source/fetch_unit.sv
source/pipe_ctrl.sv
source/rv_core_top.sv
test/tb_imem_model.sv
test/tb_rv_core.sv

/* run_sim.sh */
#!/bin/sh
# build and run the core testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    -f compile.f \
    --top-module tb_rv_core \
    -o sim_rv_core

./obj_dir/sim_rv_core | tee sim.log

grep -q "TB PASSED" sim.log
